/* rtl/raster_pkg.sv */
package raster_pkg;

    // Fixed point format shared by the raster pipeline
    // Upper SIGFIG-RADIX bits hold the integer part, lower RADIX bits the fraction
    localparam int SIGFIG = 24;
    localparam int RADIX  = 10;

    // Triangle geometry and color layout
    localparam int VERTS  = 3;
    // x, y and z per vertex
    localparam int AXIS   = 3;
    localparam int COLORS = 3;

    // One-hot subsample code to step size
    // Code 1000 shifted by RADIX-3 lands on bit RADIX, one whole pixel
    localparam int STEP_SHIFT = RADIX - 3;

    // Signed screen or depth position
    typedef logic signed [SIGFIG-1:0] coord_t;

    // Unsigned color channel
    typedef logic [SIGFIG-1:0] chan_t;

    // Multisample code
    // 1000 = 1x, 0100 = 4x, 0010 = 16x, 0001 = 64x
    typedef logic [3:0] subsample_t;

    // Sample location on screen
    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // Triangle vertex with depth
    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    // Bounding box, lower-left and upper-right corners
    typedef struct packed {
        point_t ll;
        point_t ur;
    } box_t;

    // Triangle payload carried with every sample
    typedef struct packed {
        vertex_t [VERTS-1:0] verts;
        chan_t   [COLORS-1:0] color;
    } prim_t;

    // Iterator FSM states
    typedef enum logic {
        WAIT_STATE,
        TEST_STATE
    } state_t;

endpackage

/* rtl/sample_stepper.sv */
module sample_stepper (
    // Current sample and the box being walked
    input  raster_pkg::point_t     sample,
    input  raster_pkg::box_t       box,
    // Multisample code, sets the step size
    input  raster_pkg::subsample_t subsample,
    // Next position in the walk
    output raster_pkg::point_t     next_walk,
    // Current sample is the last one of the box
    output logic                   at_end
);

    // Step in fixed point
    raster_pkg::coord_t step;

    // Edge tests on the current sample
    logic at_right;
    logic at_top;

    // Candidate positions
    raster_pkg::point_t step_right;
    raster_pkg::point_t row_up;

    // One-hot code moved up into the fraction bits
    // 1000 gives a pixel, 0001 an eighth of a pixel
    assign step = raster_pkg::coord_t'(subsample) << raster_pkg::STEP_SHIFT;

    // Signed compares, box corners may sit left of or below the origin
    assign at_right = (sample.x >= box.ur.x);
    assign at_top   = (sample.y >= box.ur.y);

    // Move one step along the row
    always_comb begin
        step_right.x = sample.x + step;
        step_right.y = sample.y;
    end

    // Wrap back to the left edge, one row higher
    always_comb begin
        row_up.x = box.ll.x;
        row_up.y = sample.y + step;
    end

    // Left to right, then bottom to top
    always_comb begin
        if (at_right) begin
            next_walk = row_up;
        end else begin
            next_walk = step_right;
        end
    end

    // Top right corner reached
    assign at_end = at_right && at_top;

endmodule

/* rtl/iterate_ctrl.sv */
module iterate_ctrl (
    input  logic               clk,
    input  logic               rst,
    // Triangle and box from upstream
    input  raster_pkg::prim_t  prim_in,
    input  raster_pkg::box_t   box_in,
    input  logic               valid_tri,
    // Walk step from the stepper
    input  raster_pkg::point_t next_walk,
    input  logic               at_end,
    // Captured triangle and box
    output raster_pkg::prim_t  prim_out,
    output raster_pkg::box_t   box,
    // Sample under test
    output raster_pkg::point_t sample,
    output logic               valid_samp,
    // Active low hold for the upstream stage
    output logic               halt_n
);

    // Wait or test
    raster_pkg::state_t state;
    raster_pkg::state_t next_state;

    // Next values of the data registers
    raster_pkg::prim_t  next_prim;
    raster_pkg::box_t   next_box;
    raster_pkg::point_t next_sample;

    // State transitions
    always_comb begin
        case (state)
            raster_pkg::WAIT_STATE: begin
                // A valid triangle starts a walk
                if (valid_tri) begin
                    next_state = raster_pkg::TEST_STATE;
                end else begin
                    next_state = raster_pkg::WAIT_STATE;
                end
            end
            raster_pkg::TEST_STATE: begin
                // Last sample of the box ends the walk
                if (at_end) begin
                    next_state = raster_pkg::WAIT_STATE;
                end else begin
                    next_state = raster_pkg::TEST_STATE;
                end
            end
            default: begin
                next_state = raster_pkg::WAIT_STATE;
            end
        endcase
    end

    // Data path select
    always_comb begin
        if (state == raster_pkg::WAIT_STATE) begin
            // Track the inputs so an accept captures them directly
            next_prim   = prim_in;
            next_box    = box_in;
            // Walk starts at the lower-left corner
            next_sample = box_in.ll;
        end else begin
            // Hold the triangle while walking
            next_prim   = prim_out;
            next_box    = box;
            next_sample = next_walk;
        end
    end

    // Control registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= raster_pkg::WAIT_STATE;
            valid_samp <= 1'b0;
            halt_n     <= 1'b1;
        end else begin
            state      <= next_state;
            // Both follow the next state, so they stay complementary
            valid_samp <= (next_state == raster_pkg::TEST_STATE);
            halt_n     <= (next_state == raster_pkg::WAIT_STATE);
        end
    end

    // Payload and walk registers
    always_ff @(posedge clk) begin
        prim_out <= next_prim;
        box      <= next_box;
        sample   <= next_sample;
    end

endmodule

/* rtl/bbox_iterator.sv */
module bbox_iterator (
    input  logic                   clk,
    input  logic                   rst,
    // Upstream triangle, box and strobe
    input  raster_pkg::prim_t      prim_in,
    input  raster_pkg::box_t       box_in,
    input  logic                   valid_tri,
    // Multisample code, steady for the whole walk
    input  raster_pkg::subsample_t subsample,
    // Hold request to upstream, low while walking
    output logic                   halt_n,
    // To the sample test stage
    output raster_pkg::prim_t      prim_out,
    output raster_pkg::point_t     sample,
    output logic                   valid_samp
);

    // Box captured at accept
    raster_pkg::box_t   box;

    // Stepper results fed back into the controller
    raster_pkg::point_t next_walk;
    logic               at_end;

    // FSM and registers
    iterate_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .prim_in    (prim_in),
        .box_in     (box_in),
        .valid_tri  (valid_tri),
        .next_walk  (next_walk),
        .at_end     (at_end),
        .prim_out   (prim_out),
        .box        (box),
        .sample     (sample),
        .valid_samp (valid_samp),
        .halt_n     (halt_n)
    );

    // Combinational next sample and end test
    // Works on the registered sample, so the loop has one flop stage
    sample_stepper u_stepper (
        .sample    (sample),
        .box       (box),
        .subsample (subsample),
        .next_walk (next_walk),
        .at_end    (at_end)
    );

endmodule

/* verification/raster_sva.sv */
module raster_sva (
    input logic               clk,
    input logic               rst,
    input raster_pkg::state_t state,
    input logic               valid_tri,
    input logic               at_end,
    input raster_pkg::box_t   box,
    input raster_pkg::point_t sample,
    input logic               valid_samp,
    input logic               halt_n
);

    timeunit 1ns;
    timeprecision 1ps;

    // Accept in the waiting state starts a walk
    property accept_starts_walk;
        @(posedge clk) disable iff (rst)
        (state == raster_pkg::WAIT_STATE && valid_tri) |=> (state == raster_pkg::TEST_STATE);
    endproperty

    // Last sample of the box returns the FSM to waiting
    property end_stops_walk;
        @(posedge clk) disable iff (rst)
        (state == raster_pkg::TEST_STATE && at_end) |=> (state == raster_pkg::WAIT_STATE);
    endproperty

    // Sample never below or left of the box
    // Last column or row may pass the far edge by less than one step, at most a pixel
    property sample_in_box;
        @(posedge clk) disable iff (rst)
        valid_samp |->
            (sample.x >= box.ll.x) && (sample.y >= box.ll.y) &&
            (int'(sample.x) < int'(box.ur.x) + (1 << raster_pkg::RADIX)) &&
            (int'(sample.y) < int'(box.ur.y) + (1 << raster_pkg::RADIX));
    endproperty

    // Upstream hold is the inverse of the sample strobe
    property halt_tracks_valid;
        @(posedge clk) disable iff (rst)
        halt_n == !valid_samp;
    endproperty

    assert property (accept_starts_walk)
        else $error("Accept in WAIT_STATE did not move the FSM to TEST_STATE");

    assert property (end_stops_walk)
        else $error("at_end in TEST_STATE did not return the FSM to WAIT_STATE");

    assert property (sample_in_box)
        else $error("Valid sample lies outside the registered box");

    assert property (halt_tracks_valid)
        else $error("halt_n is not the inverse of valid_samp");

endmodule

// Attach to every controller instance
bind iterate_ctrl raster_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .state      (state),
    .valid_tri  (valid_tri),
    .at_end     (at_end),
    .box        (box),
    .sample     (sample),
    .valid_samp (valid_samp),
    .halt_n     (halt_n)
);

/* verification/bbox_iterator_tb.sv */
module bbox_iterator_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // DUT ports
    logic                   clk;
    logic                   rst;
    raster_pkg::prim_t      prim_in;
    raster_pkg::box_t       box_in;
    logic                   valid_tri;
    raster_pkg::subsample_t subsample;
    logic                   halt_n;
    raster_pkg::prim_t      prim_out;
    raster_pkg::point_t     sample;
    logic                   valid_samp;

    // 20 cases of 8 hex words each
    logic [31:0] case_mem [0:159];

    integer seed;
    int     checks;
    int     mismatches;
    int     other_errors;
    bit     aborted;
    string  case_name;
    int     idx;

    bbox_iterator dut (
        .clk        (clk),
        .rst        (rst),
        .prim_in    (prim_in),
        .box_in     (box_in),
        .valid_tri  (valid_tri),
        .subsample  (subsample),
        .halt_n     (halt_n),
        .prim_out   (prim_out),
        .sample     (sample),
        .valid_samp (valid_samp)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // Random vertices and colors
    task automatic random_prim(output raster_pkg::prim_t p);
        for (int v = 0; v < raster_pkg::VERTS; v++) begin
            p.verts[v].x = raster_pkg::coord_t'($random(seed));
            p.verts[v].y = raster_pkg::coord_t'($random(seed));
            p.verts[v].z = raster_pkg::coord_t'($random(seed));
        end
        for (int c = 0; c < raster_pkg::COLORS; c++) begin
            p.color[c] = raster_pkg::chan_t'($random(seed));
        end
    endtask

    // Junk box for cycles where the DUT must ignore its inputs
    task automatic random_box(output raster_pkg::box_t b);
        b.ll.x = raster_pkg::coord_t'($random(seed));
        b.ll.y = raster_pkg::coord_t'($random(seed));
        b.ur.x = raster_pkg::coord_t'($random(seed));
        b.ur.y = raster_pkg::coord_t'($random(seed));
    endtask

    // Drive on the rising edge, then sample outputs mid cycle
    task automatic drive_cycle(input logic vt, input raster_pkg::prim_t p,
                               input raster_pkg::box_t b, input raster_pkg::subsample_t code);
        @(posedge clk);
        valid_tri <= vt;
        prim_in   <= p;
        box_in    <= b;
        subsample <= code;
        @(negedge clk);
    endtask

    // One cycle with no triangle and fresh junk on the data inputs
    task automatic junk_cycle();
        raster_pkg::prim_t p;
        raster_pkg::box_t  b;
        random_prim(p);
        random_box(b);
        drive_cycle(1'b0, p, b, subsample);
    endtask

    task automatic check_point(input string what, input raster_pkg::point_t exp,
                               input raster_pkg::point_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s %s: expected x=%h y=%h actual x=%h y=%h",
                     case_name, what, exp.x, exp.y, act.x, act.y);
        end
    endtask

    task automatic check_prim(input string what, input raster_pkg::prim_t exp,
                              input raster_pkg::prim_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s %s: expected %h actual %h", case_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s %s: expected %b actual %b", case_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        checks++;
        if (act != exp) begin
            mismatches++;
            $display("Mismatch %s %s: expected %0d actual %0d", case_name, what, exp, act);
        end
    endtask

    // One pixel at 1x down to an eighth of a pixel at 64x
    function automatic int step_of(input raster_pkg::subsample_t code);
        int one_pixel;
        one_pixel = 1 << raster_pkg::RADIX;
        case (code)
            4'b1000: return one_pixel;
            4'b0100: return one_pixel / 2;
            4'b0010: return one_pixel / 4;
            4'b0001: return one_pixel / 8;
            default: return 0;
        endcase
    endfunction

    // Start position plus the steps needed to reach or pass the far edge
    function automatic int axis_count(input int lo, input int hi, input int step);
        int n;
        n = 0;
        while (lo + n * step < hi && n < 100000) begin
            n++;
        end
        return n + 1;
    endfunction

    // Idle gap, accept, then follow the whole walk against the model
    task automatic run_case(input int num);
        raster_pkg::subsample_t code;
        raster_pkg::box_t       box;
        raster_pkg::prim_t      prim;
        raster_pkg::prim_t      junk_prim;
        raster_pkg::box_t       junk_box;
        raster_pkg::point_t     exp_pt;
        int                     base;
        int                     file_count;
        int                     idle;
        int                     model_count;
        int                     step;
        int                     mx;
        int                     my;
        int                     seen;
        int                     waited;
        int                     i;
        bit                     last;

        base = num * 8;
        case_name = $sformatf("case %0d", case_mem[base]);
        code = case_mem[base + 1][3:0];
        box.ll.x = case_mem[base + 2][23:0];
        box.ll.y = case_mem[base + 3][23:0];
        box.ur.x = case_mem[base + 4][23:0];
        box.ur.y = case_mem[base + 5][23:0];
        file_count = case_mem[base + 6];
        idle = case_mem[base + 7];

        // Columns times rows, must agree with the data file
        step = step_of(code);
        model_count = axis_count(box.ll.x, box.ur.x, step) *
                      axis_count(box.ll.y, box.ur.y, step);
        check_count("count rule", file_count, model_count);

        // First idle cycle doubles as the finish cycle of the previous walk
        for (i = 0; i < idle; i++) begin
            junk_cycle();
            check_flag("idle valid_samp", 1'b0, valid_samp);
            check_flag("idle halt_n", 1'b1, halt_n);
        end

        // Present the triangle, accepted at the next edge
        random_prim(prim);
        drive_cycle(1'b1, prim, box, code);
        check_flag("ready valid_samp", 1'b0, valid_samp);
        check_flag("ready halt_n", 1'b1, halt_n);

        // Wait for the first sample, 8 cycle limit
        waited = 0;
        while (valid_samp !== 1'b1 && waited < 8) begin
            random_prim(junk_prim);
            random_box(junk_box);
            drive_cycle(1'b0, junk_prim, junk_box, code);
            waited++;
        end
        if (valid_samp !== 1'b1) begin
            other_errors++;
            aborted = 1'b1;
            $display("Timeout: %s was never accepted, valid_samp stayed low", case_name);
            return;
        end
        if (waited != 1) begin
            other_errors++;
            $display("%s was accepted after %0d cycles instead of one", case_name, waited);
        end

        // Walk model starts at the lower-left corner
        mx = box.ll.x;
        my = box.ll.y;
        seen = 0;
        last = 1'b0;
        while (!last && seen < 4096) begin
            exp_pt.x = raster_pkg::coord_t'(mx);
            exp_pt.y = raster_pkg::coord_t'(my);
            seen++;
            check_point("sample", exp_pt, sample);
            check_prim("prim_out", prim, prim_out);
            check_flag("walk halt_n", 1'b0, halt_n);
            if (mx >= box.ur.x && my >= box.ur.y) begin
                last = 1'b1;
            end else begin
                // Step right inside the row, else wrap to the next row up
                if (mx < box.ur.x) begin
                    mx = mx + step;
                end else begin
                    mx = box.ll.x;
                    my = my + step;
                end
                // Inputs change under the hold, the DUT must ignore them
                random_prim(junk_prim);
                random_box(junk_box);
                drive_cycle(1'b0, junk_prim, junk_box, code);
                if (valid_samp !== 1'b1) begin
                    other_errors++;
                    $display("%s: valid_samp dropped after %0d samples", case_name, seen);
                    last = 1'b1;
                end
            end
        end
        if (!last) begin
            other_errors++;
            aborted = 1'b1;
            $display("Timeout: %s walk did not end within 4096 samples", case_name);
            return;
        end
        check_count("sample count", file_count, seen);
    endtask

    initial begin
        seed = 32'hdffe;
        checks = 0;
        mismatches = 0;
        other_errors = 0;
        aborted = 1'b0;
        case_name = "reset";
        clk = 1'b0;
        rst = 1'b1;
        valid_tri = 1'b0;
        prim_in = '0;
        box_in = '0;
        subsample = 4'b1000;

        $readmemh("verification/raster_cases.txt", case_mem);
        if (case_mem[0] === 32'bx) begin
            other_errors++;
            aborted = 1'b1;
            $display("Could not read the case file verification/raster_cases.txt");
        end

        // Reset held for 10 cycles
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("valid_samp", 1'b0, valid_samp);
        check_flag("halt_n", 1'b1, halt_n);

        for (idx = 0; idx < 20 && !aborted; idx++) begin
            run_case(idx);
        end

        // Finish cycle of the last walk
        if (!aborted) begin
            case_name = "final";
            junk_cycle();
            check_flag("finish valid_samp", 1'b0, valid_samp);
            check_flag("finish halt_n", 1'b1, halt_n);
        end

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* bbox_iterator.f */
rtl/raster_pkg.sv
rtl/sample_stepper.sv
rtl/iterate_ctrl.sv
rtl/bbox_iterator.sv
verification/raster_sva.sv
verification/bbox_iterator_tb.sv

/* verification/raster_cases.txt */
// case  code  ll.x    ll.y    ur.x    ur.y    count  idle
// All hex, coordinates are 24-bit signed fixed point with 10 fraction bits
01 8 000000 000000 000C00 000800 0C 2
02 8 001400 001000 001400 001000 01 0
03 4 000100 000000 000900 000500 14 1
04 2 000000 000000 000380 000200 0F 0
05 1 000400 000400 000600 000500 0F 2
06 8 FFF800 FFFC00 000400 000200 0C 0
07 1 000123 000456 000123 000456 01 0
08 4 000000 000000 000000 000700 05 3
09 2 000010 000020 000410 000020 05 1
0A 8 002000 003000 002A00 003500 0C 0
0B 1 FFFF00 FFFF80 000040 000000 08 2
0C 4 000000 000000 000A00 000A00 24 1
0D 8 000000 000000 000000 000000 01 0
0E 2 000000 000000 0000FF 0000FF 04 0
0F 1 000000 000000 000080 000080 04 4
10 8 000200 000200 000A00 000300 06 1
11 4 FFFE00 FFFE00 000200 000200 09 0
12 1 000000 000000 000400 000000 09 2
13 2 000000 000000 000000 000301 05 0
14 8 000001 000001 000402 000001 03 1
